//--- rtl/fe_cmd_pkg.sv
package fe_cmd_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // host command word

   localparam int CMD_W    = 32;
   localparam int OP_MSB   = 31;                        // opcode field
   localparam int OP_LSB   = 28;
   localparam int TGT_MSB  = 27;                        // spi target, xfer only
   localparam int TGT_LSB  = 26;
   localparam int DATA_MSB = 15;                        // spi word or tx sample
   localparam int DATA_LSB = 0;
   localparam int DATA_W   = DATA_MSB - DATA_LSB + 1;

   typedef enum logic [3:0] {
      OP_NOP      = 4'h0,
      OP_SPI_XFER = 4'h1,
      OP_RX_READ  = 4'h2,                               // latest adc i/q pair
      OP_TX_SET_I = 4'h3,
      OP_TX_SET_Q = 4'h4
   } cmd_op_e;

   ////////////////////////////////////////////////////////////////////////////
   // response word, opcode echo reuses the command position

   localparam int RESP_W  = 32;
   localparam int ERR_BIT = 27;
   localparam int PAY_MSB = 23;
   localparam int PAY_LSB = 0;
   localparam int PAY_W   = PAY_MSB - PAY_LSB + 1;

   localparam int ADC_W = 12;                           // ad9862 rx sample
   localparam int DAC_W = 14;                           // ad9862 tx sample
endpackage

//--- rtl/fe_spi_pkg.sv
package fe_spi_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // devices on the shared spi bus

   typedef enum logic [1:0] {
      TGT_CODEC = 2'd0,
      TGT_TX_DB = 2'd1,
      TGT_RX_DB = 2'd2                                  // code 3 has no device
   } spi_tgt_e;

   localparam int N_DEV = 3;

   ////////////////////////////////////////////////////////////////////////////
   // transfer shape, mode 0, msb first

   localparam int SPI_BITS  = 16;
   localparam int SPI_DIV   = 2;                        // clk cycles per half sclk
   localparam int BIT_CNT_W = $clog2(SPI_BITS);
   localparam int DIV_CNT_W = $clog2(SPI_DIV);

   localparam logic [BIT_CNT_W-1:0] BIT_LAST = BIT_CNT_W'(SPI_BITS - 1);
   localparam logic [DIV_CNT_W-1:0] DIV_LAST = DIV_CNT_W'(SPI_DIV - 1);

   typedef enum logic [1:0] {
      IDLE,
      SHIFT_LO,                                         // sclk low, mosi settles
      SHIFT_HI,                                         // sclk high, miso sampled
      DONE                                              // enable hold time
   } spi_state_e;
endpackage

//--- rtl/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode (
   input  logic                               clk_fpga,
   input  logic                               reset_i,
   input  logic                               cmd_valid_i,
   input  logic [fe_cmd_pkg::CMD_W-1:0]       cmd_data_i,
   output logic                               cmd_ready_o,
   output logic                               dec_valid_o,
   input  logic                               dec_ready_i,
   output fe_cmd_pkg::cmd_op_e                dec_op_o,
   output fe_spi_pkg::spi_tgt_e               dec_tgt_o,
   output logic [fe_cmd_pkg::DATA_W-1:0]      dec_data_o,
   output logic                               dec_err_o
);

   logic [3:0] op_raw;
   logic [1:0] tgt_raw;
   logic       op_known;
   logic       bad_cmd;

   assign op_raw  = cmd_data_i[fe_cmd_pkg::OP_MSB:fe_cmd_pkg::OP_LSB];
   assign tgt_raw = cmd_data_i[fe_cmd_pkg::TGT_MSB:fe_cmd_pkg::TGT_LSB];

   always_comb
   begin
      case (op_raw)
         fe_cmd_pkg::OP_NOP,
         fe_cmd_pkg::OP_SPI_XFER,
         fe_cmd_pkg::OP_RX_READ,
         fe_cmd_pkg::OP_TX_SET_I,
         fe_cmd_pkg::OP_TX_SET_Q: op_known = 1'b1;
         default:                 op_known = 1'b0;  // reserved opcode
      endcase
   end

   // target only checked for spi, other opcodes ignore the field
   assign bad_cmd = !op_known ||
                    ((op_raw == fe_cmd_pkg::OP_SPI_XFER) && (tgt_raw >= fe_spi_pkg::N_DEV));

   assign cmd_ready_o = !dec_valid_o;                // single slot

   always_ff @(posedge clk_fpga)
   begin
      if (reset_i)
         dec_valid_o <= 1'b0;
      else if (cmd_valid_i && cmd_ready_o)
         dec_valid_o <= 1'b1;
      else if (dec_ready_i)
         dec_valid_o <= 1'b0;                        // execute took it
   end

   always_ff @(posedge clk_fpga)
   begin
      if (cmd_valid_i && cmd_ready_o)
      begin
         dec_op_o   <= fe_cmd_pkg::cmd_op_e'(op_raw);
         dec_tgt_o  <= fe_spi_pkg::spi_tgt_e'(tgt_raw);
         dec_data_o <= cmd_data_i[fe_cmd_pkg::DATA_MSB:fe_cmd_pkg::DATA_LSB];
         dec_err_o  <= bad_cmd;
      end
   end

   // a stalled command must not change under execute
   a_dec_hold: assert property (@(posedge clk_fpga) disable iff (reset_i)
      dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(dec_op_o));

endmodule

//--- rtl/spi_engine.sv
`timescale 1ns/1ps

module spi_engine (
   input  logic                               clk_fpga,
   input  logic                               reset_i,
   input  logic                               dec_valid_i,
   output logic                               dec_ready_o,
   input  fe_cmd_pkg::cmd_op_e                dec_op_i,
   input  fe_spi_pkg::spi_tgt_e               dec_tgt_i,
   input  logic [fe_cmd_pkg::DATA_W-1:0]      dec_data_i,
   input  logic                               dec_err_i,
   output logic                               ex_valid_o,
   input  logic                               ex_ready_i,
   output fe_cmd_pkg::cmd_op_e                ex_op_o,
   output logic                               ex_err_o,
   output logic [fe_cmd_pkg::PAY_W-1:0]       ex_payload_o,
   input  logic [fe_cmd_pkg::ADC_W-1:0]       rx_i_i,
   input  logic [fe_cmd_pkg::ADC_W-1:0]       rx_q_i,
   output logic                               tx_i_load_o,
   output logic                               tx_q_load_o,
   output logic [fe_cmd_pkg::DAC_W-1:0]       tx_word_o,
   output logic                               sclk_codec_o,
   output logic                               sen_codec_o,
   output logic                               mosi_codec_o,
   input  logic                               miso_codec_i,
   output logic                               sclk_tx_db_o,
   output logic                               sen_tx_db_o,
   output logic                               mosi_tx_db_o,
   input  logic                               miso_tx_db_i,
   output logic                               sclk_rx_db_o,
   output logic                               sen_rx_db_o,
   output logic                               mosi_rx_db_o,
   input  logic                               miso_rx_db_i
);

   fe_spi_pkg::spi_state_e                state;
   logic [fe_spi_pkg::N_DEV-1:0]          sen_q;     // active low, one per device
   logic                                  sclk_q;
   logic [fe_spi_pkg::DIV_CNT_W-1:0]      div_cnt;
   logic [fe_spi_pkg::BIT_CNT_W-1:0]      bit_cnt;
   logic [fe_spi_pkg::SPI_BITS-1:0]       tx_sh;     // mosi is the msb
   logic [fe_spi_pkg::SPI_BITS-1:0]       rx_sh;
   logic                                  miso;
   logic                                  take;
   logic                                  div_end;
   logic                                  ok_cmd;

   assign take    = dec_valid_i && dec_ready_o;
   assign div_end = (div_cnt == fe_spi_pkg::DIV_LAST);
   assign ok_cmd  = take && !dec_err_i;

   // free output slot, or one leaving this cycle
   assign dec_ready_o = (state == fe_spi_pkg::IDLE) && (!ex_valid_o || ex_ready_i);

   ////////////////////////////////////////////////////////////////////////////
   // device routing, deselected devices see quiet lines

   assign sen_codec_o  = sen_q[fe_spi_pkg::TGT_CODEC];
   assign sen_tx_db_o  = sen_q[fe_spi_pkg::TGT_TX_DB];
   assign sen_rx_db_o  = sen_q[fe_spi_pkg::TGT_RX_DB];
   assign sclk_codec_o = sclk_q & ~sen_codec_o;
   assign sclk_tx_db_o = sclk_q & ~sen_tx_db_o;
   assign sclk_rx_db_o = sclk_q & ~sen_rx_db_o;
   assign mosi_codec_o = tx_sh[fe_spi_pkg::SPI_BITS-1] & ~sen_codec_o;
   assign mosi_tx_db_o = tx_sh[fe_spi_pkg::SPI_BITS-1] & ~sen_tx_db_o;
   assign mosi_rx_db_o = tx_sh[fe_spi_pkg::SPI_BITS-1] & ~sen_rx_db_o;
   assign miso = (~sen_codec_o & miso_codec_i) | (~sen_tx_db_o & miso_tx_db_i) |
                 (~sen_rx_db_o & miso_rx_db_i);

   ////////////////////////////////////////////////////////////////////////////
   // control FSM

   always_ff @(posedge clk_fpga)
   begin
      if (reset_i)
      begin
         state       <= fe_spi_pkg::IDLE;
         sen_q       <= '1;
         sclk_q      <= 1'b0;
         div_cnt     <= '0;
         bit_cnt     <= '0;
         ex_valid_o  <= 1'b0;
         tx_i_load_o <= 1'b0;
         tx_q_load_o <= 1'b0;
      end
      else
      begin
         tx_i_load_o <= ok_cmd && (dec_op_i == fe_cmd_pkg::OP_TX_SET_I);  // one cycle pulse
         tx_q_load_o <= ok_cmd && (dec_op_i == fe_cmd_pkg::OP_TX_SET_Q);
         if (ex_valid_o && ex_ready_i)
            ex_valid_o <= 1'b0;
         if (state != fe_spi_pkg::IDLE)
            div_cnt <= div_end ? '0 : div_cnt + 1'b1;
         case (state)
            fe_spi_pkg::IDLE:
               if (ok_cmd && (dec_op_i == fe_cmd_pkg::OP_SPI_XFER))
               begin
                  sen_q[dec_tgt_i] <= 1'b0;             // half period before first rise
                  state            <= fe_spi_pkg::SHIFT_LO;
               end
               else if (take)
                  ex_valid_o <= 1'b1;                   // read, set, nop and errors
            fe_spi_pkg::SHIFT_LO:
               if (div_end)
               begin
                  sclk_q <= 1'b1;
                  state  <= fe_spi_pkg::SHIFT_HI;
               end
            fe_spi_pkg::SHIFT_HI:
               if (div_end)
               begin
                  sclk_q  <= 1'b0;
                  bit_cnt <= bit_cnt + 1'b1;            // wraps to 0 after last bit
                  state   <= (bit_cnt == fe_spi_pkg::BIT_LAST) ? fe_spi_pkg::DONE
                                                               : fe_spi_pkg::SHIFT_LO;
               end
            default:
               if (div_end)
               begin
                  sen_q      <= '1;
                  ex_valid_o <= 1'b1;
                  state      <= fe_spi_pkg::IDLE;
               end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // shift registers and result payload

   always_ff @(posedge clk_fpga)
   begin
      if (take)
      begin
         ex_op_o   <= dec_op_i;
         ex_err_o  <= dec_err_i;
         tx_sh     <= dec_data_i;
         tx_word_o <= dec_data_i[fe_cmd_pkg::DAC_W-1:0];
         case (dec_op_i)
            fe_cmd_pkg::OP_RX_READ:
               ex_payload_o <= {rx_i_i, rx_q_i};
            fe_cmd_pkg::OP_TX_SET_I,
            fe_cmd_pkg::OP_TX_SET_Q:
               ex_payload_o <= {{(fe_cmd_pkg::PAY_W - fe_cmd_pkg::DAC_W){1'b0}},
                                dec_data_i[fe_cmd_pkg::DAC_W-1:0]};      // echo
            default:
               ex_payload_o <= '0;
         endcase
      end
      if ((state == fe_spi_pkg::SHIFT_LO) && div_end)
         rx_sh <= {rx_sh[fe_spi_pkg::SPI_BITS-2:0], miso};              // rising edge
      if ((state == fe_spi_pkg::SHIFT_HI) && div_end)
         tx_sh <= {tx_sh[fe_spi_pkg::SPI_BITS-2:0], 1'b0};              // falling edge
      if ((state == fe_spi_pkg::DONE) && div_end)
         ex_payload_o <= {{(fe_cmd_pkg::PAY_W - fe_spi_pkg::SPI_BITS){1'b0}}, rx_sh};
   end

   // shared bus, never two devices selected
   a_one_sen: assert property (@(posedge clk_fpga) disable iff (reset_i)
      $onehot0(~sen_q) && ((sen_q == '1) || (state != fe_spi_pkg::IDLE)));

endmodule

//--- rtl/radio_datapath.sv
`timescale 1ns/1ps

module radio_datapath (
   input  logic                               clk_fpga,
   input  logic                               reset_i,
   input  logic [fe_cmd_pkg::ADC_W-1:0]       adc_a_i,
   input  logic [fe_cmd_pkg::ADC_W-1:0]       adc_b_i,
   input  logic                               rxsync0_i,
   output logic [fe_cmd_pkg::ADC_W-1:0]       rx_i_o,
   output logic [fe_cmd_pkg::ADC_W-1:0]       rx_q_o,
   input  logic                               tx_i_load_i,
   input  logic                               tx_q_load_i,
   input  logic [fe_cmd_pkg::DAC_W-1:0]       tx_word_i,
   output logic [fe_cmd_pkg::DAC_W-1:0]       dac_d0_o,
   output logic [fe_cmd_pkg::DAC_W-1:0]       dac_d1_o
);

   logic [fe_cmd_pkg::DAC_W-1:0] tx_i;
   logic [fe_cmd_pkg::DAC_W-1:0] tx_q;

   ////////////////////////////////////////////////////////////////////////////
   // rx deinterleave
   // the codec sends i and q on alternate clock phases, sync marks
   // which phase carries i

   always_ff @(posedge clk_fpga)
   begin
      if (rxsync0_i)
      begin
         rx_i_o <= adc_a_i;                          // i on rising phase
         rx_q_o <= adc_b_i;
      end
      else
      begin
         rx_i_o <= adc_b_i;                          // swapped
         rx_q_o <= adc_a_i;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // tx words, held until the next set

   always_ff @(posedge clk_fpga)
   begin
      if (reset_i)
      begin
         tx_i <= '0;                                 // dac idles at midscale code 0
         tx_q <= '0;
      end
      else
      begin
         if (tx_i_load_i)
            tx_i <= tx_word_i;
         if (tx_q_load_i)
            tx_q <= tx_word_i;
      end
   end

   assign dac_d0_o = tx_i;                           // phase 0 to external ddr cell
   assign dac_d1_o = tx_q;                           // phase 1

endmodule

//--- rtl/resp_format.sv
`timescale 1ns/1ps

module resp_format (
   input  logic                               clk_fpga,
   input  logic                               reset_i,
   input  logic                               ex_valid_i,
   output logic                               ex_ready_o,
   input  fe_cmd_pkg::cmd_op_e                ex_op_i,
   input  logic                               ex_err_i,
   input  logic [fe_cmd_pkg::PAY_W-1:0]       ex_payload_i,
   output logic                               resp_valid_o,
   output logic [fe_cmd_pkg::RESP_W-1:0]      resp_data_o,
   input  logic                               resp_ready_i
);

   logic [fe_cmd_pkg::RESP_W-1:0] resp_next;

   always_comb
   begin
      resp_next                                      = '0;    // spare bits stay 0
      resp_next[fe_cmd_pkg::OP_MSB:fe_cmd_pkg::OP_LSB] = ex_op_i;
      resp_next[fe_cmd_pkg::ERR_BIT]                 = ex_err_i;
      if (!ex_err_i)
         resp_next[fe_cmd_pkg::PAY_MSB:fe_cmd_pkg::PAY_LSB] = ex_payload_i;
   end

   // accept when empty or when the host drains this cycle
   assign ex_ready_o = !resp_valid_o || resp_ready_i;

   always_ff @(posedge clk_fpga)
   begin
      if (reset_i)
         resp_valid_o <= 1'b0;
      else if (ex_valid_i && ex_ready_o)
         resp_valid_o <= 1'b1;
      else if (resp_ready_i)
         resp_valid_o <= 1'b0;
   end

   always_ff @(posedge clk_fpga)
   begin
      if (ex_valid_i && ex_ready_o)
         resp_data_o <= resp_next;
   end

   // host back-pressure must see a frozen word
   a_resp_hold: assert property (@(posedge clk_fpga) disable iff (reset_i)
      resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o));

endmodule

//--- rtl/frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
   input  logic                               clk_fpga,
   input  logic                               reset_i,
   input  logic                               cmd_valid_i,
   input  logic [fe_cmd_pkg::CMD_W-1:0]       cmd_data_i,
   output logic                               cmd_ready_o,
   output logic                               resp_valid_o,
   output logic [fe_cmd_pkg::RESP_W-1:0]      resp_data_o,
   input  logic                               resp_ready_i,
   output logic                               sclk_codec_o,
   output logic                               sen_codec_o,
   output logic                               mosi_codec_o,
   input  logic                               miso_codec_i,
   output logic                               sclk_tx_db_o,
   output logic                               sen_tx_db_o,
   output logic                               mosi_tx_db_o,
   input  logic                               miso_tx_db_i,
   output logic                               sclk_rx_db_o,
   output logic                               sen_rx_db_o,
   output logic                               mosi_rx_db_o,
   input  logic                               miso_rx_db_i,
   input  logic [fe_cmd_pkg::ADC_W-1:0]       adc_a_i,
   input  logic [fe_cmd_pkg::ADC_W-1:0]       adc_b_i,
   input  logic                               rxsync0_i,
   output logic [fe_cmd_pkg::DAC_W-1:0]       dac_d0_o,
   output logic [fe_cmd_pkg::DAC_W-1:0]       dac_d1_o
);

   ////////////////////////////////////////////////////////////////////////////
   // stage links

   logic                              dec_valid, dec_ready, dec_err;
   fe_cmd_pkg::cmd_op_e               dec_op;
   fe_spi_pkg::spi_tgt_e              dec_tgt;
   logic [fe_cmd_pkg::DATA_W-1:0]     dec_data;
   logic                              ex_valid, ex_ready, ex_err;
   fe_cmd_pkg::cmd_op_e               ex_op;
   logic [fe_cmd_pkg::PAY_W-1:0]      ex_payload;
   logic                              tx_i_load, tx_q_load;
   logic [fe_cmd_pkg::DAC_W-1:0]      tx_word;
   logic [fe_cmd_pkg::ADC_W-1:0]      rx_i, rx_q;

   cmd_decode cmd_decode_inst (
      .clk_fpga, .reset_i, .cmd_valid_i, .cmd_data_i, .cmd_ready_o,
      .dec_valid_o(dec_valid), .dec_ready_i(dec_ready), .dec_op_o(dec_op),
      .dec_tgt_o(dec_tgt), .dec_data_o(dec_data), .dec_err_o(dec_err));

   spi_engine spi_engine_inst (
      .clk_fpga, .reset_i,
      .dec_valid_i(dec_valid), .dec_ready_o(dec_ready), .dec_op_i(dec_op),
      .dec_tgt_i(dec_tgt), .dec_data_i(dec_data), .dec_err_i(dec_err),
      .ex_valid_o(ex_valid), .ex_ready_i(ex_ready), .ex_op_o(ex_op),
      .ex_err_o(ex_err), .ex_payload_o(ex_payload),
      .rx_i_i(rx_i), .rx_q_i(rx_q),
      .tx_i_load_o(tx_i_load), .tx_q_load_o(tx_q_load), .tx_word_o(tx_word),
      .sclk_codec_o, .sen_codec_o, .mosi_codec_o, .miso_codec_i,
      .sclk_tx_db_o, .sen_tx_db_o, .mosi_tx_db_o, .miso_tx_db_i,
      .sclk_rx_db_o, .sen_rx_db_o, .mosi_rx_db_o, .miso_rx_db_i);

   radio_datapath radio_datapath_inst (
      .clk_fpga, .reset_i, .adc_a_i, .adc_b_i, .rxsync0_i,
      .rx_i_o(rx_i), .rx_q_o(rx_q),
      .tx_i_load_i(tx_i_load), .tx_q_load_i(tx_q_load), .tx_word_i(tx_word),
      .dac_d0_o, .dac_d1_o);

   resp_format resp_format_inst (
      .clk_fpga, .reset_i,
      .ex_valid_i(ex_valid), .ex_ready_o(ex_ready), .ex_op_i(ex_op),
      .ex_err_i(ex_err), .ex_payload_i(ex_payload),
      .resp_valid_o, .resp_data_o, .resp_ready_i);

endmodule

//--- test/frontend_model.svh
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// spi device contents and expected responses

function automatic logic [15:0] dev_pattern(input int idx);
   case (idx)
      0:       return 16'hA5C3;                     // codec readback
      1:       return 16'h3C96;                     // tx daughterboard
      default: return 16'h5E21;                     // rx daughterboard
   endcase
endfunction

// response word for one command, adc values as seen when it executes
function automatic logic [31:0] expect_resp(input logic [31:0] cmd, input logic [11:0] a,
                                            input logic [11:0] b, input logic sync);
   logic [3:0]  op;
   logic [1:0]  tgt;
   logic        bad;
   logic [31:0] r;
   op  = cmd[31:28];
   tgt = cmd[27:26];
   bad = (op > fe_cmd_pkg::OP_TX_SET_Q) ||
         ((op == fe_cmd_pkg::OP_SPI_XFER) && (tgt == 2'd3));  // no fourth device
   r = '0;
   r[fe_cmd_pkg::OP_MSB:fe_cmd_pkg::OP_LSB] = op;   // opcode echo
   r[fe_cmd_pkg::ERR_BIT] = bad;
   if (!bad)
      case (op)
         fe_cmd_pkg::OP_SPI_XFER: r[15:0] = dev_pattern(tgt);
         fe_cmd_pkg::OP_RX_READ:  r[23:0] = sync ? {a, b} : {b, a};  // {i, q}
         fe_cmd_pkg::OP_TX_SET_I,
         fe_cmd_pkg::OP_TX_SET_Q: r[13:0] = cmd[13:0];               // dac word echo
         default:                 r[23:0] = '0;
      endcase
   return r;
endfunction

// mode 0 slave, sampled 1 ns after each clk edge
task automatic spi_device(input int idx);
   logic        sclk_prev;
   logic        sen_prev;
   logic [15:0] out_sh;
   logic [15:0] in_sh;
   sclk_prev   = 1'b0;
   sen_prev    = 1'b1;
   out_sh      = '0;
   in_sh       = '0;
   miso_w[idx] = 1'b0;
   forever
   begin
      @(posedge clk_fpga);
      #1;
      if (sen_w[idx] && (sclk_w[idx] || mosi_w[idx]))
      begin
         $display("device %0d saw clock or data while its enable was high", idx);
         abort_sim();
      end
      else
      begin
         if (sen_prev && !sen_w[idx])
         begin
            out_sh = dev_pattern(idx);              // msb ready before first rise
            in_sh  = '0;
         end
         else if (!sen_w[idx] && !sclk_prev && sclk_w[idx])
            in_sh = {in_sh[14:0], mosi_w[idx]};     // rising sclk, take mosi
         else if (!sen_w[idx] && sclk_prev && !sclk_w[idx])
            out_sh = {out_sh[14:0], 1'b0};          // falling sclk, next miso bit
         else if (!sen_prev && sen_w[idx])
         begin
            got_mosi[idx] = in_sh;                  // end of transfer
            xfer_cnt[idx] = xfer_cnt[idx] + 1;
         end
         miso_w[idx] = out_sh[15];
         sclk_prev   = sclk_w[idx];
         sen_prev    = sen_w[idx];
      end
   end
endtask

`endif

//--- test/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb;

   localparam int CMD_TIMEOUT   = 1000;             // cycles per command handshake
   localparam int DRAIN_TIMEOUT = 2000;
   localparam int N_STREAM      = 40;

   logic        clk_fpga;
   logic        reset_i;
   logic        cmd_valid_i;
   logic [31:0] cmd_data_i;
   logic        cmd_ready_o;
   logic        resp_valid_o;
   logic [31:0] resp_data_o;
   logic        resp_ready_i;
   logic [2:0]  sclk_w;                             // index 0 codec, 1 tx db, 2 rx db
   logic [2:0]  sen_w;
   logic [2:0]  mosi_w;
   logic        miso_w [3];
   logic [11:0] adc_a_i;
   logic [11:0] adc_b_i;
   logic        rxsync0_i;
   logic [13:0] dac_d0_o;
   logic [13:0] dac_d1_o;

   logic [31:0] exp_q [$];                          // expected responses, in order
   logic [15:0] got_mosi [3];
   int          xfer_cnt [3];
   logic        rand_ready;

   `include "frontend_model.svh"

   frontend_top frontend_top_inst (
      .clk_fpga, .reset_i, .cmd_valid_i, .cmd_data_i, .cmd_ready_o,
      .resp_valid_o, .resp_data_o, .resp_ready_i,
      .sclk_codec_o(sclk_w[0]), .sen_codec_o(sen_w[0]), .mosi_codec_o(mosi_w[0]),
      .miso_codec_i(miso_w[0]),
      .sclk_tx_db_o(sclk_w[1]), .sen_tx_db_o(sen_w[1]), .mosi_tx_db_o(mosi_w[1]),
      .miso_tx_db_i(miso_w[1]),
      .sclk_rx_db_o(sclk_w[2]), .sen_rx_db_o(sen_w[2]), .mosi_rx_db_o(mosi_w[2]),
      .miso_rx_db_i(miso_w[2]),
      .adc_a_i, .adc_b_i, .rxsync0_i, .dac_d0_o, .dac_d1_o);

   ////////////////////////////////////////////////////////////////////////////
   // helpers

   task automatic abort_sim();
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("ERR %0t %s got 0x%h expected 0x%h", $time, name, got, exp);
         abort_sim();
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk_fpga);
         #1;
      end
   endtask

   // called 1 ns after an edge, returns 1 ns after the accepting edge
   task automatic send_cmd(input logic [31:0] cmd);
      logic accepted;
      int   waited;
      accepted    = 1'b0;
      waited      = 0;
      cmd_valid_i = 1'b1;
      cmd_data_i  = cmd;
      exp_q.push_back(expect_resp(cmd, adc_a_i, adc_b_i, rxsync0_i));
      while (!accepted && (waited < CMD_TIMEOUT))
      begin
         @(negedge clk_fpga);
         accepted = cmd_ready_o;                    // taken at the coming edge
         @(posedge clk_fpga);
         #1;
         waited++;
      end
      if (!accepted)
      begin
         $display("timeout: command 0x%h not accepted after %0d cycles", cmd, waited);
         abort_sim();
      end
      else
         cmd_valid_i = 1'b0;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while ((exp_q.size() != 0) && (waited < DRAIN_TIMEOUT))
      begin
         @(posedge clk_fpga);
         #1;
         waited++;
      end
      if (exp_q.size() != 0)
      begin
         $display("timeout: %0d responses never arrived", exp_q.size());
         abort_sim();
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // clock, devices, host ready, response compare

   initial
   begin
      clk_fpga = 1'b0;
      forever #5 clk_fpga = ~clk_fpga;
   end

   initial
   begin
      fork
         spi_device(0);
         spi_device(1);
         spi_device(2);
      join
   end

   initial
   begin
      resp_ready_i = 1'b1;
      forever
      begin
         @(posedge clk_fpga);
         #1;
         resp_ready_i = rand_ready ? ($urandom_range(0, 1) == 1) : 1'b1;  // host stalls
      end
   end

   initial
   begin
      forever
      begin
         @(negedge clk_fpga);
         if (resp_valid_o && resp_ready_i)          // transfer on the next edge
         begin
            if (exp_q.size() == 0)
            begin
               $display("response 0x%h arrived with no command outstanding", resp_data_o);
               abort_sim();
            end
            else
               check_eq("resp_data_o", resp_data_o, exp_q.pop_front());
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // stimulus

   initial
   begin
      int          t;
      int          d;
      int          n;
      int          cnt_before [3];
      logic [15:0] word;
      logic [3:0]  op_raw;
      logic [1:0]  tgt;
      logic [31:0] cmd;
      void'($urandom(94));
      reset_i     = 1'b1;
      cmd_valid_i = 1'b0;
      cmd_data_i  = '0;
      adc_a_i     = '0;
      adc_b_i     = '0;
      rxsync0_i   = 1'b0;
      rand_ready  = 1'b0;
      repeat (2) @(posedge clk_fpga);
      #1;
      reset_i = 1'b0;

      // idle outputs straight out of reset
      check_eq("cmd_ready_o", cmd_ready_o, 1);
      check_eq("resp_valid_o", resp_valid_o, 0);
      for (d = 0; d < 3; d++)
      begin
         check_eq($sformatf("sen_w[%0d]", d), sen_w[d], 1);
         check_eq($sformatf("sclk_w[%0d]", d), sclk_w[d], 0);
         check_eq($sformatf("mosi_w[%0d]", d), mosi_w[d], 0);
      end
      check_eq("dac_d0_o", dac_d0_o, 0);
      check_eq("dac_d1_o", dac_d1_o, 0);

      // one transfer per device, others stay quiet
      for (t = 0; t < 3; t++)
      begin
         for (d = 0; d < 3; d++)
            cnt_before[d] = xfer_cnt[d];
         word = $urandom;
         send_cmd({fe_cmd_pkg::OP_SPI_XFER, t[1:0], 10'd0, word});
         wait_drain();
         check_eq($sformatf("got_mosi[%0d]", t), got_mosi[t], word);
         for (d = 0; d < 3; d++)
            check_eq($sformatf("xfer_cnt[%0d]", d), xfer_cnt[d], cnt_before[d] + (d == t));
      end

      // adc read, both sync phases
      adc_a_i   = 12'h5A3;
      adc_b_i   = 12'hC1E;
      rxsync0_i = 1'b1;
      idle_cycles(3);                               // let rx registers settle
      send_cmd({fe_cmd_pkg::OP_RX_READ, 28'd0});
      wait_drain();
      rxsync0_i = 1'b0;
      idle_cycles(3);
      send_cmd({fe_cmd_pkg::OP_RX_READ, 28'd0});
      wait_drain();

      // dac words, top two data bits dropped
      send_cmd({fe_cmd_pkg::OP_TX_SET_I, 12'd0, 16'hEB7D});
      send_cmd({fe_cmd_pkg::OP_TX_SET_Q, 12'd0, 16'h1234});
      wait_drain();
      check_eq("dac_d0_o", dac_d0_o, 14'h2B7D);
      check_eq("dac_d1_o", dac_d1_o, 14'h1234);

      // reserved opcode and the missing fourth device
      for (d = 0; d < 3; d++)
         cnt_before[d] = xfer_cnt[d];
      send_cmd({4'hB, 28'h0000123});
      send_cmd({fe_cmd_pkg::OP_SPI_XFER, 2'd3, 10'd0, 16'hBEEF});
      wait_drain();
      for (d = 0; d < 3; d++)
         check_eq($sformatf("xfer_cnt[%0d]", d), xfer_cnt[d], cnt_before[d]);

      // mixed stream under host back-pressure
      rand_ready = 1'b1;
      for (n = 0; n < N_STREAM; n++)
      begin
         idle_cycles($urandom_range(0, 3));          // random command gap
         case ($urandom_range(0, 5))
            0:       op_raw = fe_cmd_pkg::OP_SPI_XFER;
            1:       op_raw = fe_cmd_pkg::OP_RX_READ;
            2:       op_raw = fe_cmd_pkg::OP_TX_SET_I;
            3:       op_raw = fe_cmd_pkg::OP_TX_SET_Q;
            4:       op_raw = fe_cmd_pkg::OP_NOP;
            default: op_raw = $urandom_range(5, 15);  // reserved
         endcase
         tgt  = $urandom_range(0, 3);
         word = $urandom;
         cmd  = {op_raw, tgt, 10'd0, word};
         send_cmd(cmd);
      end
      rand_ready = 1'b0;
      wait_drain();
      // pipeline empty, no extra response behind the last one
      check_eq("resp_valid_o", resp_valid_o, 0);
      check_eq("cmd_ready_o", cmd_ready_o, 1);

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

//--- flist.f
+incdir+test
rtl/fe_cmd_pkg.sv
rtl/fe_spi_pkg.sv
rtl/cmd_decode.sv
rtl/spi_engine.sv
rtl/radio_datapath.sv
rtl/resp_format.sv
rtl/frontend_top.sv
test/frontend_tb.sv

//--- Bender.yml
package:
  name: frontend

sources:
  - files:
      - rtl/fe_cmd_pkg.sv
      - rtl/fe_spi_pkg.sv
      - rtl/cmd_decode.sv
      - rtl/spi_engine.sv
      - rtl/radio_datapath.sv
      - rtl/resp_format.sv
      - rtl/frontend_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/frontend_tb.sv
